//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_openram_testchip
RTL_TOP    ?= openram_testchip
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= All checks passed
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= -Wall
RTL_FILES  ?= source/testchip_pkg.sv source/scan_register.sv \
              source/port_decode.sv source/openram_testchip.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+verif
source/testchip_pkg.sv
source/scan_register.sv
source/port_decode.sv
source/openram_testchip.sv
verif/tb_openram_testchip.sv

//--- source/openram_testchip.sv
module openram_testchip import testchip_pkg::*; (
	input  logic                   clk,
	input  logic                   resetn,

	// logic analyzer side
	input  logic                   la_in_load_i,
	input  logic                   la_sram_load_i,
	input  logic [total_width-1:0] la_data_i,

	// gpio side
	input  logic                   gpio_i,
	input  logic                   gpio_scan_i,
	input  logic                   gpio_sram_load_i,
	input  logic                   global_csb_i,

	// read data coming back from every sram
	input  logic [data_width-1:0]  sram_dout0_i [max_chips],
	input  logic [data_width-1:0]  sram_dout1_i [max_chips],

	// shared sram port buses
	output logic [addr_width-1:0]  addr0_o,
	output logic [data_width-1:0]  din0_o,
	output logic                   web0_o,
	output logic [wmask_width-1:0] wmask0_o,
	output logic [addr_width-1:0]  addr1_o,
	output logic [data_width-1:0]  din1_o,
	output logic                   web1_o,
	output logic [wmask_width-1:0] wmask1_o,
	output logic [max_chips-1:0]   csb0_o,
	output logic [max_chips-1:0]   csb1_o,

	output logic [total_width-1:0] la_data_o,
	output logic                   gpio_o    // msb of the word, scan out
);

	logic [total_width-1:0]  sram_reg;
	logic [select_width-1:0] chip_select;
	logic                    capture;

	// either side may ask for the read data
	assign capture = la_sram_load_i | gpio_sram_load_i;

	scan_register u_scan_register (
		.clk           (clk),
		.resetn        (resetn),
		.gpio_scan_i   (gpio_scan_i),
		.gpio_i        (gpio_i),
		.la_in_load_i  (la_in_load_i),
		.capture_i     (capture),
		.load_data_i   (la_data_i),
		.sram_dout0_i  (sram_dout0_i),
		.sram_dout1_i  (sram_dout1_i),
		.sram_reg_o    (sram_reg),
		.chip_select_o (chip_select)
	);

	port_decode u_port_decode (
		.sram_reg_i    (sram_reg),
		.chip_select_i (chip_select),
		.global_csb_i  (global_csb_i),
		.addr0_o       (addr0_o),
		.din0_o        (din0_o),
		.web0_o        (web0_o),
		.wmask0_o      (wmask0_o),
		.addr1_o       (addr1_o),
		.din1_o        (din1_o),
		.web1_o        (web1_o),
		.wmask1_o      (wmask1_o),
		.csb0_o        (csb0_o),
		.csb1_o        (csb1_o)
	);

	assign la_data_o = sram_reg;
	assign gpio_o    = sram_reg[total_width-1];

endmodule

//--- source/port_decode.sv
module port_decode import testchip_pkg::*; (
	input  logic [total_width-1:0]  sram_reg_i,
	input  logic [select_width-1:0] chip_select_i,
	input  logic                    global_csb_i,   // high turns every sram off

	// port 0 bus, shared by all srams
	output logic [addr_width-1:0]   addr0_o,
	output logic [data_width-1:0]   din0_o,
	output logic                    web0_o,
	output logic [wmask_width-1:0]  wmask0_o,

	// port 1 bus
	output logic [addr_width-1:0]   addr1_o,
	output logic [data_width-1:0]   din1_o,
	output logic                    web1_o,
	output logic [wmask_width-1:0]  wmask1_o,

	// active low, one bit per sram
	output logic [max_chips-1:0]    csb0_o,
	output logic [max_chips-1:0]    csb1_o
);

	logic [port_width-1:0] port0_cmd;
	logic [port_width-1:0] port1_cmd;
	logic                  csb0_en;  // active low enable of port 0
	logic                  csb1_en;

	// place an active low enable at the selected position, rest stays high
	function automatic logic [max_chips-1:0] place_csb(
		input logic                    csb,
		input logic [select_width-1:0] sel
	);
		logic [max_chips-1:0] low_bit;
		low_bit = {{(max_chips-1){1'b0}}, ~csb};
		return ~(low_bit << sel);
	endfunction

	assign port0_cmd = sram_reg_i[port0_lsb +: port_width];
	assign port1_cmd = sram_reg_i[0 +: port_width];

	assign addr0_o  = port0_cmd[addr_lsb +: addr_width];
	assign din0_o   = port0_cmd[din_lsb +: data_width];
	assign web0_o   = port0_cmd[web_bit];
	assign wmask0_o = port0_cmd[wmask_lsb +: wmask_width];

	assign addr1_o  = port1_cmd[addr_lsb +: addr_width];
	assign din1_o   = port1_cmd[din_lsb +: data_width];
	assign web1_o   = port1_cmd[web_bit];
	assign wmask1_o = port1_cmd[wmask_lsb +: wmask_width];

	// global disable wins over the per port csb bit
	assign csb0_en = port0_cmd[csb_bit] | global_csb_i;
	assign csb1_en = port1_cmd[csb_bit] | global_csb_i;

	assign csb0_o = place_csb(csb0_en, chip_select_i);
	assign csb1_o = place_csb(csb1_en, chip_select_i);

	// the select comes from the register word, so the low csb bit must sit
	// where the word's own select field points
	always_comb begin
		if (!$isunknown(sram_reg_i)) begin
			a_sel_match: assert (chip_select_i == sram_reg_i[select_lsb +: select_width]);
		end
	end

endmodule

//--- source/scan_register.sv
module scan_register import testchip_pkg::*; (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    gpio_scan_i,   // shift one bit in from gpio_i
	input  logic                    gpio_i,
	input  logic                    la_in_load_i,  // parallel load from the la bus
	input  logic                    capture_i,     // store read data of the selected sram
	input  logic [total_width-1:0]  load_data_i,
	input  logic [data_width-1:0]   sram_dout0_i [max_chips],
	input  logic [data_width-1:0]   sram_dout1_i [max_chips],
	output logic [total_width-1:0]  sram_reg_o,
	output logic [select_width-1:0] chip_select_o
);

	logic [total_width-1:0]  sram_reg;
	logic [select_width-1:0] chip_select;
	logic [data_width-1:0]   read_data0;  // port 0 dout of the selected sram
	logic [data_width-1:0]   read_data1;

	// the select field names the macro that gets the chip select and
	// also the one whose read data is captured
	assign chip_select = sram_reg[select_lsb +: select_width];

	// read mux, registered only on the capture edge
	assign read_data0 = sram_dout0_i[chip_select];
	assign read_data1 = sram_dout1_i[chip_select];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			sram_reg <= '0;
		end else if (gpio_scan_i) begin
			sram_reg <= {sram_reg[total_width-2:0], gpio_i};  // msb leaves on gpio_o
		end else if (la_in_load_i) begin
			sram_reg <= load_data_i;
		end else if (capture_i) begin
			// only the two din fields change, address and control stay
			sram_reg[port0_lsb + din_lsb +: data_width] <= read_data0;
			sram_reg[din_lsb +: data_width]             <= read_data1;
		end
	end

	assign sram_reg_o    = sram_reg;
	assign chip_select_o = chip_select;

	// once out of reset the word stays fully defined
	a_reg_known: assert property (
		@(posedge clk) disable iff (!resetn)
		!$isunknown(sram_reg)
	);

endmodule

//--- source/testchip_pkg.sv
package testchip_pkg;

	// basic widths of the openram macros on the chip
	localparam int data_width   = 32;
	localparam int addr_width   = 16;
	localparam int wmask_width  = 4;   // one bit per byte of data
	localparam int select_width = 4;
	localparam int max_chips    = 16;  // 2**select_width macros

	// one port command, lsb first:
	// wmask, web, csb, din, addr
	localparam int wmask_lsb = 0;
	localparam int web_bit   = wmask_lsb + wmask_width;  // 4
	localparam int csb_bit   = web_bit + 1;              // 5
	localparam int din_lsb   = csb_bit + 1;              // 6
	localparam int addr_lsb  = din_lsb + data_width;     // 38

	localparam int port_width = addr_lsb + addr_width;   // 54

	// register word, lsb first:
	// port 1, port 0, chip select
	localparam int port0_lsb  = port_width;              // 54
	localparam int select_lsb = 2 * port_width;          // 108

	localparam int total_width = select_lsb + select_width;  // 112

endpackage

//--- verif/tb_model.svh
`ifndef tb_model_svh
`define tb_model_svh

// next register word, from the word before the edge and the strobes sampled at it
function automatic logic [total_width-1:0] next_reg(
	input logic [total_width-1:0] cur,
	input logic                   scan,
	input logic                   scan_bit,
	input logic                   load,
	input logic [total_width-1:0] load_word,
	input logic                   capture,
	input logic [data_width-1:0]  dout0 [max_chips],
	input logic [data_width-1:0]  dout1 [max_chips]
);
	logic [total_width-1:0]  nxt;
	logic [select_width-1:0] sel;
	sel = cur[select_lsb +: select_width];  // chip named before the edge
	nxt = cur;
	if (scan) begin
		nxt = {cur[total_width-2:0], scan_bit};
	end else if (load) begin
		nxt = load_word;
	end else if (capture) begin
		for (int b = 0; b < data_width; b++) begin
			nxt[port0_lsb + din_lsb + b] = dout0[sel][b];
			nxt[din_lsb + b]             = dout1[sel][b];
		end
	end
	return nxt;
endfunction

function automatic logic [port_width-1:0] port_cmd(
	input logic [total_width-1:0] word,
	input logic                   is_port0
);
	return is_port0 ? word[port0_lsb +: port_width] : word[port_width-1:0];
endfunction

// every chip off except the selected one, which follows the port's own csb bit
function automatic logic [max_chips-1:0] expected_csb(
	input logic [port_width-1:0]   cmd,
	input logic [select_width-1:0] sel,
	input logic                    global_off
);
	logic [max_chips-1:0] csb;
	csb = '1;
	if (!cmd[csb_bit] && !global_off) begin
		csb[sel] = 1'b0;
	end
	return csb;
endfunction

task automatic check_word(input string name, input logic [total_width-1:0] got, exp);
	if (got !== exp) begin
		fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	end
endtask

task automatic check_data(input string name, input logic [data_width-1:0] got, exp);
	if (got !== exp) begin
		fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	end
endtask

task automatic check_addr(input string name, input logic [addr_width-1:0] got, exp);
	if (got !== exp) begin
		fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	end
endtask

task automatic check_csb(input string name, input logic [max_chips-1:0] got, exp);
	if (got !== exp) begin
		fail_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp));
	end
endtask

task automatic check_mask(input string name, input logic [wmask_width-1:0] got, exp);
	if (got !== exp) begin
		fail_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp));
	end
endtask

task automatic check_bit(input string name, input logic got, exp);
	if (got !== exp) begin
		fail_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp));
	end
endtask

// every output of the DUT against the decode of one register word
task automatic check_outputs(input logic [total_width-1:0] word);
	logic [port_width-1:0]   p0;
	logic [port_width-1:0]   p1;
	logic [select_width-1:0] sel;
	p0  = port_cmd(word, 1'b1);
	p1  = port_cmd(word, 1'b0);
	sel = word[select_lsb +: select_width];
	check_word("la_data_o", la_data_o, word);
	check_bit("gpio_o", gpio_o, word[total_width-1]);
	check_addr("addr0_o", addr0_o, p0[addr_lsb +: addr_width]);
	check_data("din0_o", din0_o, p0[din_lsb +: data_width]);
	check_bit("web0_o", web0_o, p0[web_bit]);
	check_mask("wmask0_o", wmask0_o, p0[wmask_lsb +: wmask_width]);
	check_csb("csb0_o", csb0_o, expected_csb(p0, sel, global_csb_i));
	check_addr("addr1_o", addr1_o, p1[addr_lsb +: addr_width]);
	check_data("din1_o", din1_o, p1[din_lsb +: data_width]);
	check_bit("web1_o", web1_o, p1[web_bit]);
	check_mask("wmask1_o", wmask1_o, p1[wmask_lsb +: wmask_width]);
	check_csb("csb1_o", csb1_o, expected_csb(p1, sel, global_csb_i));
endtask

`endif

//--- verif/tb_openram_testchip.sv
module tb_openram_testchip import testchip_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                   clk;
	logic                   resetn;
	logic                   la_in_load_i;
	logic                   la_sram_load_i;
	logic [total_width-1:0] la_data_i;
	logic                   gpio_i;
	logic                   gpio_scan_i;
	logic                   gpio_sram_load_i;
	logic                   global_csb_i;
	logic [data_width-1:0]  sram_dout0_i [max_chips];  // sram model, fixed after start
	logic [data_width-1:0]  sram_dout1_i [max_chips];
	logic [addr_width-1:0]  addr0_o;
	logic [data_width-1:0]  din0_o;
	logic                   web0_o;
	logic [wmask_width-1:0] wmask0_o;
	logic [addr_width-1:0]  addr1_o;
	logic [data_width-1:0]  din1_o;
	logic                   web1_o;
	logic [wmask_width-1:0] wmask1_o;
	logic [max_chips-1:0]   csb0_o;
	logic [max_chips-1:0]   csb1_o;
	logic [total_width-1:0] la_data_o;
	logic                   gpio_o;

	logic [31:0] rng;
	logic        checking;  // set once reset is over
	int          failures;

	openram_testchip UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		failures++;
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [total_width-1:0] rand_word();
		logic [127:0] w;
		for (int k = 0; k < 4; k++) begin
			rng = xorshift32(rng);
			w[32*k +: 32] = rng;
		end
		return w[total_width-1:0];
	endfunction

	`include "tb_model.svh"

	// one cycle of strobes, set on a falling edge and dropped on the next
	task automatic pulse(input logic scan, sbit, load, la_cap, gpio_cap,
			input logic [total_width-1:0] word);
		gpio_scan_i      = scan;
		gpio_i           = sbit;
		la_in_load_i     = load;
		la_data_i        = word;
		la_sram_load_i   = la_cap;
		gpio_sram_load_i = gpio_cap;
		@(negedge clk);
		gpio_scan_i      = 1'b0;
		la_in_load_i     = 1'b0;
		la_sram_load_i   = 1'b0;
		gpio_sram_load_i = 1'b0;
	endtask

	task automatic wait_word(input logic [total_width-1:0] exp, input int limit);
		int cycles;
		cycles = 0;
		while (la_data_o !== exp) begin
			if (cycles == limit) begin
				fail_run($sformatf("register did not reach %h within %0d cycles", exp, limit));
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// shadow register, compared with the DUT just after every rising edge
	initial begin : compare_proc
		logic [total_width-1:0] shadow;
		shadow = '0;
		forever begin
			@(posedge clk);
			#1;  // inputs hold until the falling edge
			if (!resetn) begin
				shadow = '0;
			end else begin
				shadow = next_reg(shadow, gpio_scan_i, gpio_i, la_in_load_i, la_data_i,
					la_sram_load_i | gpio_sram_load_i, sram_dout0_i, sram_dout1_i);
			end
			if (checking) begin
				check_outputs(shadow);
			end
		end
	end

	initial begin : stimulus
		logic [total_width-1:0] word;
		logic [total_width-1:0] old_word;
		logic [total_width-1:0] expected;
		resetn           = 1'b0;
		la_in_load_i     = 1'b0;
		la_sram_load_i   = 1'b0;
		la_data_i        = '0;
		gpio_i           = 1'b0;
		gpio_scan_i      = 1'b0;
		gpio_sram_load_i = 1'b0;
		global_csb_i     = 1'b0;
		checking         = 1'b0;
		failures         = 0;
		rng              = 32'h3a9b_1fd8;
		for (int c = 0; c < max_chips; c++) begin
			rng = xorshift32(rng);
			sram_dout0_i[c] = rng;
			rng = xorshift32(rng);
			sram_dout1_i[c] = rng;
		end
		repeat (10) @(negedge clk);  // ten rising edges with resetn low
		resetn = 1'b1;
		wait_word('0, 4);
		checking = 1'b1;
		check_csb("csb0_o", csb0_o, {{(max_chips-1){1'b1}}, 1'b0});
		check_csb("csb1_o", csb1_o, {{(max_chips-1){1'b1}}, 1'b0});

		repeat (8) begin
			word = rand_word();
			pulse(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, word);
			check_outputs(word);
		end

		// global disable, even with both csb bits low in the word
		global_csb_i = 1'b1;
		repeat (4) begin
			word = rand_word();
			word[csb_bit] = 1'b0;
			word[port0_lsb + csb_bit] = 1'b0;
			pulse(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, word);
			check_csb("csb0_o", csb0_o, '1);
			check_csb("csb1_o", csb1_o, '1);
		end
		global_csb_i = 1'b0;

		// full scan, the old word leaves msb first
		old_word = la_data_o;
		word = rand_word();
		for (int i = total_width - 1; i >= 0; i--) begin
			check_bit("gpio_o", gpio_o, old_word[i]);
			pulse(1'b1, word[i], 1'b0, 1'b0, 1'b0, '0);
		end
		check_word("la_data_o", la_data_o, word);

		// capture from every chip, the two strobes take turns
		for (int c = 0; c < max_chips; c++) begin
			word = rand_word();
			word[select_lsb +: select_width] = c[select_width-1:0];
			pulse(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, word);
			pulse(1'b0, 1'b0, 1'b0, c[0], !c[0], '0);
			expected = word;
			expected[port0_lsb + din_lsb +: data_width] = sram_dout0_i[c];
			expected[din_lsb +: data_width] = sram_dout1_i[c];
			check_word("la_data_o", la_data_o, expected);
			check_data("din0_o", din0_o, sram_dout0_i[c]);
			check_data("din1_o", din1_o, sram_dout1_i[c]);
		end

		// strobes together, scan first, then load over capture
		old_word = la_data_o;
		word = rand_word();
		pulse(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, word);
		check_word("la_data_o", la_data_o, {old_word[total_width-2:0], 1'b1});
		pulse(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, word);
		check_word("la_data_o", la_data_o, word);

		if (failures == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
